// File: hw/cache_line_xfer.sv
// cache line transfer unit

`timescale 1ns/1ps

module cache_line_xfer (
  input  logic                                 clk,
  input  logic                                 rst,
  // cache side
  input  logic                                 i_req,
  input  logic [line_geom_pkg::addr_bits-1:0]  i_addr,
  input  io_bus_pkg::io_op_e                   i_op,
  input  logic [line_geom_pkg::line_bits-1:0]  i_wdata,
  output logic [line_geom_pkg::line_bits-1:0]  o_rdata,
  output logic                                 o_ack,
  // io bus
  input  logic                                 i_io_ready,
  input  logic [line_geom_pkg::line_bits-1:0]  i_io_rdata,
  output logic                                 o_io_valid,
  output io_bus_pkg::io_op_e                   o_io_op,
  output logic [line_geom_pkg::addr_bits-1:0]  o_io_addr,
  output logic [line_geom_pkg::line_bits-1:0]  o_io_wdata,
  output io_bus_pkg::io_size_e                 o_io_size,
  output logic [7:0]                           o_io_blks
);

  logic       req_his;     // i_req one cycle back
  logic       start;       // rising edge of i_req
  logic       is_flash;    // flash window decode
  logic       io_hs;       // io handshake this cycle
  logic       narrow;      // current transfer is flash
  logic [3:0] beat_cnt;    // flash beat index
  logic [3:0] next_beat;
  logic       last_beat;

  assign start     = i_req & ~req_his;   // held request never restarts
  assign is_flash  = i_addr[line_geom_pkg::addr_bits-1 -: 4] == io_bus_pkg::flash_region;
  assign io_hs     = o_io_valid & i_io_ready;
  assign narrow    = o_io_size == io_bus_pkg::size_word;   // size picks the mode
  assign next_beat = beat_cnt + 4'd1;
  assign last_beat = beat_cnt == 4'(line_geom_pkg::narrow_beats - 1);

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      req_his    <= 1'b0;
      o_io_valid <= 1'b0;
      o_ack      <= 1'b0;
      beat_cnt   <= 4'd0;
    end else begin
      req_his <= i_req;
      o_ack   <= 1'b0;   // single cycle pulse
      if (io_hs) begin
        if (narrow && !last_beat) begin
          beat_cnt <= next_beat;   // valid stays up
        end else begin
          o_io_valid <= 1'b0;      // line done
          o_ack      <= 1'b1;
          beat_cnt   <= 4'd0;
        end
      end else if (start && !o_io_valid) begin
        o_io_valid <= 1'b1;
        beat_cnt   <= 4'd0;
      end
    end
  end

  // request fields, held stable while valid
  always_ff @(posedge clk) begin
    if (start && !o_io_valid) begin
      o_io_op <= i_op;
      if (is_flash) begin
        o_io_addr  <= i_addr & line_geom_pkg::word_align_mask;
        o_io_wdata <= {{(line_geom_pkg::line_bits - line_geom_pkg::narrow_bits){1'b0}},
                       i_wdata[line_geom_pkg::narrow_bits-1:0]};   // beat 0
        o_io_size  <= io_bus_pkg::size_word;
        o_io_blks  <= 8'd0;   // single transfer
      end else begin
        o_io_addr  <= i_addr & line_geom_pkg::line_align_mask;
        o_io_wdata <= i_wdata;   // whole line in one go
        o_io_size  <= io_bus_pkg::size_dword;
        o_io_blks  <= line_geom_pkg::wide_blks;
      end
    end else if (io_hs && narrow && !last_beat) begin
      o_io_addr  <= o_io_addr + 32'd4;   // next word
      // beat k carries line bits 32k+31..32k
      o_io_wdata <= {{(line_geom_pkg::line_bits - line_geom_pkg::narrow_bits){1'b0}},
                     i_wdata[next_beat*line_geom_pkg::narrow_bits +: line_geom_pkg::narrow_bits]};
    end
  end

  // read line assembly
  always_ff @(posedge clk) begin
    if (io_hs) begin
      if (narrow) begin
        o_rdata[beat_cnt*line_geom_pkg::narrow_bits +: line_geom_pkg::narrow_bits] <=
          i_io_rdata[line_geom_pkg::narrow_bits-1:0];   // slice k
      end else begin
        o_rdata <= i_io_rdata;   // wide reply is the line
      end
    end
  end

  // io_valid only drops after a handshake
  a_valid_hold: assert property (@(posedge clk) disable iff (rst)
    o_io_valid && !i_io_ready |=> o_io_valid);

  // ack is one cycle wide
  a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    o_ack |=> !o_ack);

  // address held under back-pressure
  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    o_io_valid && !i_io_ready |=> $stable(o_io_addr));

endmodule

// File: hw/io_bus_pkg.sv
// io bus types and region map

package io_bus_pkg;

  // transfer direction
  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } io_op_e;

  // beat size, log2 of bytes
  typedef enum logic [2:0] {
    size_word  = 3'd2,   // 4 bytes, flash
    size_dword = 3'd3    // 8 bytes, memory burst
  } io_size_e;

  // flash window, matched on addr[31:28]
  localparam logic [3:0] flash_region = 4'h3;

  // router FSM
  typedef enum logic [1:0] {
    rt_idle,     // waiting for io_valid
    rt_wide,     // memory port busy
    rt_narrow,   // flash port busy
    rt_resp      // io_ready pulse
  } router_state_e;

endpackage

// File: hw/io_port_router.sv
// io bus port router

`timescale 1ns/1ps

module io_port_router (
  input  logic                                   clk,
  input  logic                                   rst,
  // io bus
  input  logic                                   i_io_valid,
  input  io_bus_pkg::io_op_e                     i_io_op,
  input  logic [line_geom_pkg::addr_bits-1:0]    i_io_addr,
  input  logic [line_geom_pkg::line_bits-1:0]    i_io_wdata,
  input  io_bus_pkg::io_size_e                   i_io_size,
  input  logic [7:0]                             i_io_blks,
  output logic                                   o_io_ready,
  output logic [line_geom_pkg::line_bits-1:0]    o_io_rdata,
  // memory port
  input  logic                                   i_mem_ready,
  input  logic [line_geom_pkg::line_bits-1:0]    i_mem_rdata,
  output logic                                   o_mem_valid,
  output io_bus_pkg::io_op_e                     o_mem_op,
  output logic [line_geom_pkg::addr_bits-1:0]    o_mem_addr,
  output logic [line_geom_pkg::line_bits-1:0]    o_mem_wdata,
  output logic [7:0]                             o_mem_blks,
  // flash port
  input  logic                                   i_flash_ready,
  input  logic [line_geom_pkg::narrow_bits-1:0]  i_flash_rdata,
  output logic                                   o_flash_valid,
  output io_bus_pkg::io_op_e                     o_flash_op,
  output logic [line_geom_pkg::addr_bits-1:0]    o_flash_addr,
  output logic [line_geom_pkg::narrow_bits-1:0]  o_flash_wdata
);

  io_bus_pkg::router_state_e state;

  // FSM and handshake flags
  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= io_bus_pkg::rt_idle;
      o_io_ready    <= 1'b0;
      o_mem_valid   <= 1'b0;
      o_flash_valid <= 1'b0;
    end else begin
      o_io_ready <= 1'b0;
      case (state)
        io_bus_pkg::rt_idle: if (i_io_valid) begin
          if (i_io_size == io_bus_pkg::size_word) begin   // size alone picks port
            o_flash_valid <= 1'b1;
            state         <= io_bus_pkg::rt_narrow;
          end else begin
            o_mem_valid <= 1'b1;
            state       <= io_bus_pkg::rt_wide;
          end
        end
        io_bus_pkg::rt_wide: if (i_mem_ready) begin
          o_mem_valid <= 1'b0;
          o_io_ready  <= 1'b1;
          state       <= io_bus_pkg::rt_resp;
        end
        io_bus_pkg::rt_narrow: if (i_flash_ready) begin
          o_flash_valid <= 1'b0;
          o_io_ready    <= 1'b1;
          state         <= io_bus_pkg::rt_resp;
        end
        default: state <= io_bus_pkg::rt_idle;   // back to idle after the ready pulse
      endcase
    end
  end

  // both ports load the request and valid picks the live one
  always_ff @(posedge clk) begin
    if (state == io_bus_pkg::rt_idle && i_io_valid) begin
      o_mem_op      <= i_io_op;
      o_mem_addr    <= i_io_addr;
      o_mem_wdata   <= i_io_wdata;
      o_mem_blks    <= i_io_blks;
      o_flash_op    <= i_io_op;
      o_flash_addr  <= i_io_addr;
      o_flash_wdata <= i_io_wdata[line_geom_pkg::narrow_bits-1:0];   // low word only
    end
  end

  // reply data
  always_ff @(posedge clk) begin
    if (state == io_bus_pkg::rt_wide && i_mem_ready) begin
      o_io_rdata <= i_mem_rdata;
    end else if (state == io_bus_pkg::rt_narrow && i_flash_ready) begin
      o_io_rdata <= {{(line_geom_pkg::line_bits - line_geom_pkg::narrow_bits){1'b0}},
                     i_flash_rdata};   // zero extended
    end
  end

  // one target at a time
  a_one_port: assert property (@(posedge clk) disable iff (rst)
    !(o_mem_valid && o_flash_valid));

  // ready pulses only in rt_resp while the request is still up
  a_ready_resp: assert property (@(posedge clk) disable iff (rst)
    o_io_ready |-> state == io_bus_pkg::rt_resp && i_io_valid);

endmodule

// File: hw/line_geom_pkg.sv
// cache line geometry constants

package line_geom_pkg;

  // line and address widths
  localparam int line_bits = 512;   // one cache line, 64 bytes
  localparam int addr_bits = 32;    // only top nibble decoded

  // alignment masks
  localparam logic [addr_bits-1:0] line_align_mask = 32'hffff_ffc0;   // clears low 6 bits
  localparam logic [addr_bits-1:0] word_align_mask = 32'hffff_fffc;   // clears low 2 bits

  // narrow (flash) transfer shape
  localparam int narrow_beats = 16;   // words per line
  localparam int narrow_bits  = 32;   // bits per flash word

  // wide (memory) burst shape
  // burst length as count minus one
  localparam logic [7:0] wide_blks = 8'd7;   // 8 beats of 64 bits

endpackage

// File: hw/line_xfer_top.sv
// line transfer top level

`timescale 1ns/1ps

module line_xfer_top (
  input  logic                                   clk,
  input  logic                                   rst,
  // cache side
  input  logic                                   i_req,
  input  logic [line_geom_pkg::addr_bits-1:0]    i_addr,
  input  io_bus_pkg::io_op_e                     i_op,
  input  logic [line_geom_pkg::line_bits-1:0]    i_wdata,
  output logic [line_geom_pkg::line_bits-1:0]    o_rdata,
  output logic                                   o_ack,
  // memory port
  input  logic                                   i_mem_ready,
  input  logic [line_geom_pkg::line_bits-1:0]    i_mem_rdata,
  output logic                                   o_mem_valid,
  output io_bus_pkg::io_op_e                     o_mem_op,
  output logic [line_geom_pkg::addr_bits-1:0]    o_mem_addr,
  output logic [line_geom_pkg::line_bits-1:0]    o_mem_wdata,
  output logic [7:0]                             o_mem_blks,
  // flash port
  input  logic                                   i_flash_ready,
  input  logic [line_geom_pkg::narrow_bits-1:0]  i_flash_rdata,
  output logic                                   o_flash_valid,
  output io_bus_pkg::io_op_e                     o_flash_op,
  output logic [line_geom_pkg::addr_bits-1:0]    o_flash_addr,
  output logic [line_geom_pkg::narrow_bits-1:0]  o_flash_wdata
);

  // internal io bus
  logic                                 io_valid;
  io_bus_pkg::io_op_e                   io_op;
  logic [line_geom_pkg::addr_bits-1:0]  io_addr;
  logic [line_geom_pkg::line_bits-1:0]  io_wdata;
  io_bus_pkg::io_size_e                 io_size;
  logic [7:0]                           io_blks;
  logic                                 io_ready;
  logic [line_geom_pkg::line_bits-1:0]  io_rdata;

  cache_line_xfer xfer_i (
    .clk        (clk),
    .rst        (rst),
    .i_req      (i_req),
    .i_addr     (i_addr),
    .i_op       (i_op),
    .i_wdata    (i_wdata),
    .o_rdata    (o_rdata),
    .o_ack      (o_ack),
    .i_io_ready (io_ready),
    .i_io_rdata (io_rdata),
    .o_io_valid (io_valid),
    .o_io_op    (io_op),
    .o_io_addr  (io_addr),
    .o_io_wdata (io_wdata),
    .o_io_size  (io_size),
    .o_io_blks  (io_blks)
  );

  io_port_router router_i (
    .clk           (clk),
    .rst           (rst),
    .i_io_valid    (io_valid),
    .i_io_op       (io_op),
    .i_io_addr     (io_addr),
    .i_io_wdata    (io_wdata),
    .i_io_size     (io_size),
    .i_io_blks     (io_blks),
    .o_io_ready    (io_ready),
    .o_io_rdata    (io_rdata),
    .i_mem_ready   (i_mem_ready),
    .i_mem_rdata   (i_mem_rdata),
    .o_mem_valid   (o_mem_valid),
    .o_mem_op      (o_mem_op),
    .o_mem_addr    (o_mem_addr),
    .o_mem_wdata   (o_mem_wdata),
    .o_mem_blks    (o_mem_blks),
    .i_flash_ready (i_flash_ready),
    .i_flash_rdata (i_flash_rdata),
    .o_flash_valid (o_flash_valid),
    .o_flash_op    (o_flash_op),
    .o_flash_addr  (o_flash_addr),
    .o_flash_wdata (o_flash_wdata)
  );

endmodule

// File: line_xfer_top.f
hw/line_geom_pkg.sv
hw/io_bus_pkg.sv
hw/cache_line_xfer.sv
hw/io_port_router.sv
hw/line_xfer_top.sv
tb/tb_clock_gen.sv
tb/line_xfer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the line transfer testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module line_xfer_tb -f line_xfer_top.f -o line_xfer_sim &&
sim_out=$(./obj_dir/line_xfer_sim; true) &&
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -q "TEST PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb/line_xfer_tb.sv
// line transfer testbench

`timescale 1ns/1ps

module line_xfer_tb;

  localparam int n_requests     = 14;   // directed plus random mix
  localparam int timeout_cycles = 16 * 8 * n_requests + 200;

  logic               clk;
  logic               rst;
  logic               i_req;
  logic [31:0]        i_addr;
  io_bus_pkg::io_op_e i_op;
  logic [511:0]       i_wdata;
  logic [511:0]       o_rdata;
  logic               o_ack;
  logic               i_mem_ready;
  logic [511:0]       i_mem_rdata;
  logic               o_mem_valid;
  io_bus_pkg::io_op_e o_mem_op;
  logic [31:0]        o_mem_addr;
  logic [511:0]       o_mem_wdata;
  logic [7:0]         o_mem_blks;
  logic               i_flash_ready;
  logic [31:0]        i_flash_rdata;
  logic               o_flash_valid;
  io_bus_pkg::io_op_e o_flash_op;
  logic [31:0]        o_flash_addr;
  logic [31:0]        o_flash_wdata;

  logic [511:0]       mem_lines [16];     // memory model, addr[9:6]
  logic [31:0]        flash_words [64];   // flash model, addr[7:2]
  logic [31:0]        mem_addrs [$];      // seen at each handshake
  io_bus_pkg::io_op_e mem_ops [$];
  logic [7:0]         mem_blks [$];
  logic [31:0]        flash_addrs [$];
  io_bus_pkg::io_op_e flash_ops [$];
  int                 mem_wait = -1;      // -1 means no delay drawn yet
  int                 flash_wait = -1;
  int                 cycle_cnt = 0;
  logic [31:0]        lfsr_state = 32'hbf376d11;

  tb_clock_gen clk_gen_i (.o_clk(clk), .o_rst(rst));

  line_xfer_top dut_i (.*);   // port names match

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [511:0] rand_line();
    logic [511:0] l;
    for (int w = 0; w < 16; w++) begin
      l[32*w +: 32] = rand_bits(32);
    end
    return l;
  endfunction

  // memory model, ready after a random 0..3 cycle wait
  always @(posedge clk) begin
    if (o_mem_valid && i_mem_ready) begin
      mem_addrs.push_back(o_mem_addr);
      mem_ops.push_back(o_mem_op);
      mem_blks.push_back(o_mem_blks);
      if (o_mem_op == io_bus_pkg::op_write)
        mem_lines[o_mem_addr[9:6]] = o_mem_wdata;   // whole line
      mem_wait = -1;
      #1 i_mem_ready = 1'b0;
    end else if (o_mem_valid) begin
      if (mem_wait < 0)
        mem_wait = int'(rand_bits(2));
      if (mem_wait == 0) begin
        #1;
        i_mem_rdata = mem_lines[o_mem_addr[9:6]];
        i_mem_ready = 1'b1;
      end else begin
        mem_wait--;
      end
    end
  end

  // flash model, same handshake on 32-bit words
  always @(posedge clk) begin
    if (o_flash_valid && i_flash_ready) begin
      flash_addrs.push_back(o_flash_addr);
      flash_ops.push_back(o_flash_op);
      if (o_flash_op == io_bus_pkg::op_write)
        flash_words[o_flash_addr[7:2]] = o_flash_wdata;
      flash_wait = -1;
      #1 i_flash_ready = 1'b0;
    end else if (o_flash_valid) begin
      if (flash_wait < 0)
        flash_wait = int'(rand_bits(2));
      if (flash_wait == 0) begin
        #1;
        i_flash_rdata = flash_words[o_flash_addr[7:2]];
        i_flash_ready = 1'b1;
      end else begin
        flash_wait--;
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("o_ack never arrived within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $fatal(1, "run stopped on timeout");
    end
  end

  task automatic check_line(input string name, input logic [511:0] exp,
                            input logic [511:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, got %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, got %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_op(input string name, input io_bus_pkg::io_op_e exp,
                          input io_bus_pkg::io_op_e act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, got %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, got %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // raise i_req off the edge, wait for the ack pulse
  task automatic run_xfer(input logic [31:0] addr, input io_bus_pkg::io_op_e op,
                          input logic [511:0] wdata, input bit hold);
    @(posedge clk);
    #1;
    i_addr  = addr;
    i_op    = op;
    i_wdata = wdata;
    i_req   = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!o_ack);
    if (!hold)
      i_req = 1'b0;
  endtask

  // one line request, checked against the models
  task automatic xfer_check(input logic [31:0] addr, input io_bus_pkg::io_op_e op,
                            input logic [511:0] wdata, input bit hold);
    logic         flash;
    logic [31:0]  base;
    logic [5:0]   widx;
    logic [511:0] exp;
    int           n_mem;
    int           n_flash;
    flash   = addr[31:28] == 4'h3;   // flash window
    base    = flash ? {addr[31:2], 2'b00} : {addr[31:6], 6'd0};
    n_mem   = mem_addrs.size();
    n_flash = flash_addrs.size();
    for (int k = 0; k < 16; k++) begin
      widx = base[7:2] + 6'(k);
      exp[32*k +: 32] = flash ? flash_words[widx] : mem_lines[base[9:6]][32*k +: 32];
    end
    run_xfer(addr, op, wdata, hold);
    if (flash) begin
      check_word("flash transfer count", 32'(n_flash + 16), 32'(flash_addrs.size()));
      check_word("memory transfer count", 32'(n_mem), 32'(mem_addrs.size()));
      for (int k = 0; k < 16; k++) begin
        widx = base[7:2] + 6'(k);
        check_addr("o_flash_addr", base + 32'(4 * k), flash_addrs[n_flash + k]);
        check_op("o_flash_op", op, flash_ops[n_flash + k]);
        if (op == io_bus_pkg::op_write)
          check_word("flash word", wdata[32*k +: 32], flash_words[widx]);   // beat k
      end
    end else begin
      check_word("memory transfer count", 32'(n_mem + 1), 32'(mem_addrs.size()));
      check_word("flash transfer count", 32'(n_flash), 32'(flash_addrs.size()));
      check_addr("o_mem_addr", base, mem_addrs[n_mem]);
      check_op("o_mem_op", op, mem_ops[n_mem]);
      check_word("o_mem_blks", 32'd7, {24'd0, mem_blks[n_mem]});   // 8 beats
      if (op == io_bus_pkg::op_write)
        check_line("memory line", wdata, mem_lines[base[9:6]]);
    end
    if (op == io_bus_pkg::op_read)
      check_line("o_rdata", exp, o_rdata);
  endtask

  task automatic test_wide_read();
    xfer_check(32'h0000_0a5c, io_bus_pkg::op_read, '0, 1'b0);   // unaligned
  endtask

  task automatic test_wide_write();
    xfer_check(32'h0000_0480, io_bus_pkg::op_write, rand_line(), 1'b0);
  endtask

  task automatic test_flash_read();
    xfer_check(32'h3000_0046, io_bus_pkg::op_read, '0, 1'b0);   // low bits dropped
  endtask

  task automatic test_flash_write();
    xfer_check(32'h3000_00c0, io_bus_pkg::op_write, rand_line(), 1'b0);
  endtask

  // i_req left high, nothing may restart
  task automatic test_held_request();
    int n_mem;
    int n_flash;
    xfer_check(32'h0000_0700, io_bus_pkg::op_read, '0, 1'b1);
    n_mem   = mem_addrs.size();
    n_flash = flash_addrs.size();
    repeat (30) @(posedge clk);
    #1;
    check_word("memory transfer count", 32'(n_mem), 32'(mem_addrs.size()));
    check_word("flash transfer count", 32'(n_flash), 32'(flash_addrs.size()));
    i_req = 1'b0;   // rearm the edge
    xfer_check(32'h3000_0200, io_bus_pkg::op_read, '0, 1'b0);
  endtask

  task automatic test_random_mix();
    logic [31:0]        a;
    io_bus_pkg::io_op_e op;
    for (int n = 0; n < 8; n++) begin
      a        = rand_bits(28);
      a[31:28] = rand_bits(1) ? 4'h3 : 4'h1;   // flash or memory
      op       = rand_bits(1) ? io_bus_pkg::op_write : io_bus_pkg::op_read;
      xfer_check(a, op, rand_line(), 1'b0);
    end
  endtask

  initial begin
    i_req         = 1'b0;
    i_addr        = '0;
    i_op          = io_bus_pkg::op_read;
    i_wdata       = '0;
    i_mem_ready   = 1'b0;
    i_mem_rdata   = '0;
    i_flash_ready = 1'b0;
    i_flash_rdata = '0;
    for (int i = 0; i < 16; i++) begin
      for (int k = 0; k < 16; k++) begin
        mem_lines[i][32*k +: 32] = {16'h3ace, 4'(i), 8'h00, 4'(k)};   // line and word
      end
    end
    for (int j = 0; j < 64; j++) begin
      flash_words[j] = {16'hf1a5, 10'd0, 6'(j)};
    end
    wait (!rst);
    test_wide_read();
    test_wide_write();
    test_flash_read();
    test_flash_write();
    test_held_request();
    test_random_mix();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: tb/tb_clock_gen.sv
// testbench clock and reset

`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst
);

  // 100 ns period
  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk;
  end

  // sync reset, four cycles
  initial begin
    o_rst = 1'b1;
    repeat (4) @(posedge o_clk);
    #1 o_rst = 1'b0;   // off the edge like other inputs
  end

endmodule
